//--- mips.f
mipsPkg.sv
mipsAlu.sv
mipsControl.sv
mipsRegFile.sv
mipsPcUnit.sv
singleCycleMips.sv
mipsDataMem.sv
mipsSystem.sv
mipsTb.sv

//--- mipsAlu.sv
// 32-bit ALU for and, or, add, sub and signed slt, with a zero flag
`timescale 1ns/1ps

module mipsAlu (
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  mipsPkg::aluOpE op,
  output logic [31:0]    result,
  output logic           zero
);
  import mipsPkg::*;

  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);  // signed compare for slt

  always_comb begin
    case (op)
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluSlt:  result = {31'd0, lessThan};
      default: result = 32'd0;  // aluNone
    endcase
  end

  // zero follows the result for every op, beq just happens to use it
  assign zero = (result == 32'd0);

endmodule

//--- mipsControl.sv
// main decoder plus ALU control, turns opcode and funct into the control struct
`timescale 1ns/1ps

module mipsControl (
  input  logic [31:0]   instr,
  output mipsPkg::ctrlT ctrl
);
  import mipsPkg::*;

  opcodeE op;
  functE  fn;

  assign op = opcodeE'(instr[31:26]);
  assign fn = functE'(instr[5:0]);

  always_comb begin
    ctrl       = '0;       // everything off by default
    ctrl.aluOp = aluNone;
    case (op)
      opRtype: begin
        case (fn)
          fnAdd, fnSub, fnAnd, fnOr, fnSlt: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            case (fn)
              fnAdd:   ctrl.aluOp = aluAdd;
              fnSub:   ctrl.aluOp = aluSub;
              fnAnd:   ctrl.aluOp = aluAnd;
              fnOr:    ctrl.aluOp = aluOr;
              default: ctrl.aluOp = aluSlt;
            endcase
          end
          fnJr:    ctrl.jumpReg = 1'b1;  // target from rs
          default: ;                     // unknown funct, no-op
        endcase
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;  // base + offset
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;    // zero flag means equal
      end
      opJ:   ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;                 // unknown opcode falls through as a no-op
    endcase

    // a store never also writes the register file
    assert (!(ctrl.memWrite && ctrl.regWrite))
      else $error("decode sets memWrite and regWrite together");
  end

endmodule

//--- mipsDataMem.sv
// word-addressed data RAM, async read and clocked write
`timescale 1ns/1ps

module mipsDataMem #(
  parameter int dmemAddrW = 7
) (
  input  logic             clk,
  input  mipsPkg::dmemReqT req,
  output logic [31:0]      rdata
);

  localparam int depth = 2 ** dmemAddrW;

  logic [31:0] mem [depth];

  // contents start cleared
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = 32'd0;
    end
  end

  // ==================================================
  // access
  // ==================================================
  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.addr[dmemAddrW-1:0]] <= req.wdata;
    end
  end

  assign rdata = mem[req.addr[dmemAddrW-1:0]];  // same-cycle load data

endmodule

//--- mipsPcUnit.sv
// PC register and next-PC select for sequential, branch, jump and jr
`timescale 1ns/1ps

module mipsPcUnit (
  input  logic          clk,
  input  logic          rst,
  output logic [31:0]   pc,
  output logic [31:0]   pcPlus4,
  input  mipsPkg::ctrlT ctrl,
  input  logic          aluZero,
  input  logic [31:0]   branchOffset,  // already sign-extended
  input  logic [25:0]   jumpIndex,
  input  logic [31:0]   rsValue
);
  import mipsPkg::*;

  logic [31:0] nextPc;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic        branchTaken;

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};  // same 256MB region
  assign branchTaken  = ctrl.branch && aluZero;

  // jr first, then j/jal, then taken beq
  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rsValue;
    end else if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= resetPc;  // held here for the whole reset
    end else begin
      pc <= nextPc;
    end
  end

  // covers jr too, which takes whatever rs holds
  aPcAligned : assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pc lost word alignment: %h", pc);

endmodule

//--- mipsPkg.sv
// shared types for the single-cycle MIPS core: opcodes, ALU ops, control and bus structs
package mipsPkg;

  // ==================================================
  // instruction encodings
  // ==================================================
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeE;

  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functE;

  typedef enum logic [3:0] {
    aluAnd  = 4'b0000,
    aluOr   = 4'b0001,
    aluAdd  = 4'b0010,
    aluSub  = 4'b0110,
    aluSlt  = 4'b0111,
    aluNone = 4'b1111  // result forced to zero
  } aluOpE;

  // ==================================================
  // structs and constants
  // ==================================================
  localparam logic [31:0] resetPc = 32'h0000_0000;
  localparam int dmemAddrBits = 7;  // word address field, 128 words

  typedef struct packed {
    logic  regDst;    // dest is rd, else rt
    logic  aluSrc;    // second operand is the immediate
    logic  memToReg;
    logic  regWrite;
    logic  memWrite;
    logic  branch;
    logic  jump;
    logic  link;      // jal, writes pc+4 to r31
    logic  jumpReg;
    aluOpE aluOp;
  } ctrlT;

  typedef struct packed {
    logic                    we;
    logic [dmemAddrBits-1:0] addr;   // word address
    logic [31:0]             wdata;
  } dmemReqT;

  typedef struct packed {
    logic        valid;
    logic [4:0]  addr;
    logic [31:0] data;
  } regWbT;

endpackage

//--- mipsRegFile.sv
// register file, r1..r31 with r0 tied to zero, two async reads and one clocked write
`timescale 1ns/1ps

module mipsRegFile (
  input  logic           clk,
  input  logic           rst,
  input  logic [4:0]     rdAddr1,
  input  logic [4:0]     rdAddr2,
  output logic [31:0]    rdData1,
  output logic [31:0]    rdData2,
  input  mipsPkg::regWbT wb
);

  logic [31:0] regs [1:31];  // no storage for r0

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wb.valid) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // read ports, r0 always zero
  assign rdData1 = (rdAddr1 == 5'd0) ? 32'd0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == 5'd0) ? 32'd0 : regs[rdAddr2];

  // datapath must filter r0 writes before they get here
  aWbNotR0 : assert property (@(posedge clk) disable iff (!rst)
    wb.valid |-> (wb.addr != 5'd0))
    else $error("valid register write aimed at r0");

endmodule

//--- mipsSystem.sv
// system top, MIPS core with its local data memory
`timescale 1ns/1ps

module mipsSystem #(
  parameter int dmemAddrW = 7  // 128 words by default
) (
  input  logic           clk,
  input  logic           rst,
  output logic [31:0]    instrAddr,
  input  logic [31:0]    instr,
  output mipsPkg::regWbT wb
);
  import mipsPkg::*;

  dmemReqT     dmemReq;
  logic [31:0] dmemRdata;

  singleCycleMips #(.dmemAddrW(dmemAddrW)) uCore (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

  mipsDataMem #(.dmemAddrW(dmemAddrW)) uDataMem (
    .clk   (clk),
    .req   (dmemReq),
    .rdata (dmemRdata)
  );

endmodule

//--- mipsTb.sv
// testbench for the MIPS system, directed and random programs checked against a reference model
`timescale 1ns/1ps

module mipsTb;
  import mipsPkg::*;

  localparam int dmemAddrW = 7;
  // run lengths in cycles, reset adds 7 per test
  localparam int cycReset = 3;
  localparam int cycAlu   = 12;
  localparam int cycMem   = 9;
  localparam int cycCtrl  = 10;
  localparam int cycZero  = 7;
  localparam int cycRand  = 1500;
  localparam int totalCycles = cycReset + cycAlu + cycMem + cycCtrl + cycZero + cycRand + 6 * 7;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  regWbT       wb;

  logic [31:0] imem [64];            // instruction memory served by the tb
  logic [31:0] mPc;                  // model state
  logic [31:0] mRegs [32];
  logic [31:0] mMem [2**dmemAddrW];  // never cleared, like the DUT RAM
  integer      seed;
  int          testErrors;
  int          totalErrors;
  int          testsRun;
  int          testsFailed;

  mipsSystem #(.dmemAddrW(dmemAddrW)) u_mipsSystem (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .wb        (wb)
  );

  assign instr = imem[instrAddr[7:2]];  // combinational fetch, wraps every 64 words

  always #5 clk = ~clk;

  // ==================================================
  // encoders and random picks
  // ==================================================
  function automatic logic [31:0] rType(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jType(logic [5:0] op, logic [25:0] idx);
    return {op, idx};
  endfunction

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [4:0] pickDest();  // never r28, r29 (bases) or r31 (link)
    int r;
    r = randBelow(29);
    return (r == 28) ? 5'd30 : 5'(r);
  endfunction

  function automatic logic [4:0] pickBase();
    int r;
    r = randBelow(3);
    return (r == 0) ? 5'd0 : ((r == 1) ? 5'd28 : 5'd29);
  endfunction

  function automatic logic [5:0] pickAluFunct();
    case (randBelow(5))
      0:       return fnAdd;
      1:       return fnSub;
      2:       return fnAnd;
      3:       return fnOr;
      default: return fnSlt;
    endcase
  endfunction

  // ==================================================
  // reference model
  // ==================================================
  task automatic modelStep(output logic expV, output logic [4:0] expA,
                           output logic [31:0] expD);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] pc4;
    logic [31:0] npc;
    logic [31:0] addr;
    ins  = imem[mPc[7:2]];
    a    = mRegs[ins[25:21]];
    b    = mRegs[ins[20:16]];
    sext = {{16{ins[15]}}, ins[15:0]};
    pc4  = mPc + 32'd4;
    npc  = pc4;             // default, also for no-ops
    expV = 1'b0;
    expA = 5'd0;
    expD = 32'd0;
    addr = a + sext;
    case (ins[31:26])
      6'h00: begin
        expA = ins[15:11];
        expV = ins[5:0] inside {6'h20, 6'h22, 6'h24, 6'h25, 6'h2a};  // alu functs write rd
        case (ins[5:0])
          6'h20: expD = a + b;
          6'h22: expD = a - b;
          6'h24: expD = a & b;
          6'h25: expD = a | b;
          6'h2a: expD = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          6'h08: npc = a;   // jr
          default: ;
        endcase
      end
      6'h02: npc = {pc4[31:28], ins[25:0], 2'b00};
      6'h03: begin
        npc  = {pc4[31:28], ins[25:0], 2'b00};
        expV = 1'b1;
        expA = 5'd31;
        expD = pc4;         // link value
      end
      6'h04: if (a == b) npc = pc4 + {sext[29:0], 2'b00};
      6'h23: begin
        expV = 1'b1;
        expA = ins[20:16];
        expD = mMem[addr[dmemAddrW+1:2]];
      end
      6'h2b: mMem[addr[dmemAddrW+1:2]] = b;
      default: ;            // unsupported opcode
    endcase
    if (expA == 5'd0) expV = 1'b0;  // r0 never written
    if (expV) mRegs[expA] = expD;
    mPc = npc;
  endtask

  // ==================================================
  // checking and sequencing
  // ==================================================
  task automatic showError(string sig, logic [31:0] exp, logic [31:0] act);
    $display("ERROR %s expected %h actual %h at %0t", sig, exp, act, $time);
    testErrors++;
  endtask

  task automatic checkCycle();
    logic        expV;
    logic [4:0]  expA;
    logic [31:0] expD;
    logic [31:0] expPc;
    expPc = mPc;
    modelStep(expV, expA, expD);
    if (instrAddr !== expPc) showError("instrAddr", expPc, instrAddr);
    if (wb.valid !== expV) showError("wb.valid", 32'(expV), 32'(wb.valid));
    if (expV && wb.addr !== expA) showError("wb.addr", 32'(expA), 32'(wb.addr));
    if (expV && wb.data !== expD) showError("wb.data", expD, wb.data);
  endtask

  task automatic runCycles(int n);
    repeat (n) begin
      @(negedge clk);  // mid-cycle, everything settled
      checkCycle();
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1 rst = 1'b0;
    for (int k = 0; k < 5; k++) begin
      @(posedge clk);
      #1;
      if (instrAddr !== resetPc) showError("instrAddr", resetPc, instrAddr);
      if (wb.valid !== 1'b0) showError("wb.valid", 32'd0, 32'(wb.valid));
    end
    rst = 1'b1;                   // released right after the 5th edge
    mPc = resetPc;
    for (int i = 0; i < 32; i++) mRegs[i] = 32'd0;
  endtask

  task automatic clearProgram();
    for (int i = 0; i < 64; i++) imem[i] = 32'd0;  // all-zero word decodes as a no-op
  endtask

  task automatic finishTest(string name);
    testsRun++;
    if (testErrors != 0) testsFailed++;
    $display("test %s finished with %0d errors", name, testErrors);
    totalErrors += testErrors;
    testErrors = 0;
  endtask

  task automatic buildRandomProgram();
    int kind;
    logic [4:0] s1;
    logic [4:0] s2;
    logic [4:0] d;
    clearProgram();
    imem[0] = jType(opJal, 26'd1);                  // r31 = 4
    imem[1] = rType(fnAdd, 5'd31, 5'd31, 5'd28);    // r28 = 8
    imem[2] = rType(fnAdd, 5'd28, 5'd28, 5'd29);    // r29 = 16
    for (int i = 3; i < 64; i++) begin
      kind = randBelow(20);
      s1   = 5'(randBelow(32));
      s2   = 5'(randBelow(32));
      d    = pickDest();
      if (kind < 9) imem[i] = rType(pickAluFunct(), s1, s2, d);
      else if (kind < 12) imem[i] = iType(opLw, pickBase(), d, 16'(4 * randBelow(100)));
      else if (kind < 14) imem[i] = iType(opSw, pickBase(), s2, 16'(4 * randBelow(100)));
      else if (kind < 16) imem[i] = iType(opBeq, s1, s2, 16'(randBelow(8)));  // forward only
      else if (kind == 16) imem[i] = jType(opJ, 26'((i + 1 + randBelow(8)) % 64));
      else if (kind == 17) imem[i] = jType(opJal, 26'((i + 1 + randBelow(8)) % 64));
      else if (kind == 18) imem[i] = rType(fnJr, 5'd31, 5'd0, 5'd0);
      else imem[i] = iType(6'h08, s1, d, 16'h0004);  // addi, not supported
    end
  endtask

  // ==================================================
  // tests
  // ==================================================
  initial begin
    clk = 1'b0;
    rst = 1'b0;
    seed = 32'hb4609bac;
    testErrors = 0;
    totalErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    mPc = resetPc;
    for (int i = 0; i < 2**dmemAddrW; i++) mMem[i] = 32'd0;
    clearProgram();

    // reset, first slot is a no-op so wb stays low
    imem[1] = jType(opJal, 26'd2);
    imem[2] = rType(fnAdd, 5'd31, 5'd31, 5'd1);
    applyReset();
    runCycles(cycReset);
    finishTest("reset");

    // alu ops, negatives built from the jal link value
    applyReset();
    clearProgram();
    imem[0]  = jType(opJal, 26'd1);
    imem[1]  = rType(fnAdd, 5'd31, 5'd31, 5'd1);
    imem[2]  = rType(fnSub, 5'd0, 5'd1, 5'd2);
    imem[3]  = rType(fnSub, 5'd0, 5'd31, 5'd3);
    imem[4]  = rType(fnAnd, 5'd1, 5'd2, 5'd4);
    imem[5]  = rType(fnOr, 5'd2, 5'd31, 5'd5);
    imem[6]  = rType(fnSlt, 5'd2, 5'd3, 5'd6);
    imem[7]  = rType(fnSlt, 5'd3, 5'd2, 5'd7);
    imem[8]  = rType(fnSlt, 5'd2, 5'd1, 5'd8);
    imem[9]  = rType(fnSlt, 5'd1, 5'd2, 5'd9);
    imem[10] = rType(fnAdd, 5'd2, 5'd3, 5'd10);
    imem[11] = rType(fnSub, 5'd10, 5'd2, 5'd11);
    runCycles(cycAlu);
    finishTest("alu");

    // store then load same word and an untouched one
    applyReset();
    clearProgram();
    imem[0] = jType(opJal, 26'd1);
    imem[1] = rType(fnAdd, 5'd31, 5'd31, 5'd1);
    imem[2] = rType(fnSub, 5'd0, 5'd1, 5'd2);
    imem[3] = iType(opSw, 5'd1, 5'd2, 16'd12);   // word 5
    imem[4] = iType(opLw, 5'd0, 5'd3, 16'd20);
    imem[5] = iType(opLw, 5'd0, 5'd4, 16'd24);
    imem[6] = iType(opSw, 5'd0, 5'd31, 16'd24);
    imem[7] = iType(opLw, 5'd1, 5'd5, 16'd16);
    runCycles(cycMem);
    finishTest("memory");

    // branches and jumps
    applyReset();
    clearProgram();
    imem[0]  = jType(opJal, 26'd1);
    imem[1]  = iType(opBeq, 5'd0, 5'd31, 16'd5);   // not taken
    imem[2]  = iType(opBeq, 5'd0, 5'd0, 16'd1);    // taken to 4
    imem[3]  = rType(fnAdd, 5'd31, 5'd31, 5'd9);
    imem[4]  = jType(opJ, 26'd6);
    imem[5]  = rType(fnAdd, 5'd31, 5'd31, 5'd9);
    imem[6]  = jType(opJal, 26'd10);
    imem[7]  = rType(fnAdd, 5'd31, 5'd0, 5'd5);
    imem[8]  = iType(opBeq, 5'd0, 5'd0, 16'hffff); // spin here
    imem[10] = rType(fnJr, 5'd31, 5'd0, 5'd0);
    runCycles(cycCtrl);
    finishTest("control");

    // r0 targets and unsupported encodings
    applyReset();
    clearProgram();
    imem[0] = jType(opJal, 26'd1);
    imem[1] = rType(fnAdd, 5'd31, 5'd31, 5'd0);
    imem[2] = iType(opLw, 5'd0, 5'd0, 16'd20);
    imem[3] = iType(6'h08, 5'd31, 5'd5, 16'h0010);
    imem[4] = rType(6'h3f, 5'd31, 5'd31, 5'd5);
    imem[5] = iType(6'h0f, 5'd0, 5'd6, 16'hffff);
    runCycles(cycZero);
    finishTest("noop");

    applyReset();
    buildRandomProgram();
    runCycles(cycRand);
    finishTest("random");

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
    if (totalErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog, twice the planned length
  initial begin
    #(2 * totalCycles * 10);
    $display("watchdog timeout, the tests did not complete in time");
    $display("Verification failed");
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the MIPS testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mipsTb -f mips.f -o mipsSim

output=$(./obj_dir/mipsSim)
echo "$output"

if grep -q "Verification passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- singleCycleMips.sv
// single-cycle MIPS datapath, wires decode, registers, ALU and PC together
`timescale 1ns/1ps

module singleCycleMips #(
  parameter int dmemAddrW = 7
) (
  input  logic             clk,
  input  logic             rst,
  output logic [31:0]      instrAddr,
  input  logic [31:0]      instr,
  output mipsPkg::dmemReqT dmemReq,
  input  logic [31:0]      dmemRdata,
  output mipsPkg::regWbT   wb
);
  import mipsPkg::*;

  // ==================================================
  // instruction fields
  // ==================================================
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic [25:0] jumpIndex;
  logic [31:0] signExt;

  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];
  assign signExt   = {{16{imm[15]}}, imm};

  ctrlT        ctrl;
  logic [31:0] rsValue;
  logic [31:0] rtValue;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [4:0]  destAddr;
  logic [31:0] wbData;

  mipsControl uControl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  mipsRegFile uRegFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (rs),
    .rdAddr2 (rt),
    .rdData1 (rsValue),
    .rdData2 (rtValue),
    .wb      (wb)
  );

  mipsAlu uAlu (
    .a      (rsValue),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  mipsPcUnit uPcUnit (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .pcPlus4      (pcPlus4),
    .ctrl         (ctrl),
    .aluZero      (aluZero),
    .branchOffset (signExt),
    .jumpIndex    (jumpIndex),
    .rsValue      (rsValue)
  );

  assign instrAddr = pc;

  // ==================================================
  // operand and writeback muxes
  // ==================================================
  assign aluB     = ctrl.aluSrc ? signExt : rtValue;
  assign destAddr = ctrl.link ? 5'd31 : (ctrl.regDst ? rd : rt);  // jal -> r31
  assign wbData   = ctrl.link     ? pcPlus4 :
                    ctrl.memToReg ? dmemRdata : aluResult;

  assign wb.valid = rst && ctrl.regWrite && (destAddr != 5'd0);  // r0 writes dropped
  assign wb.addr  = destAddr;
  assign wb.data  = wbData;

  // memory request, byte address -> word address
  assign dmemReq.we    = rst && ctrl.memWrite;
  assign dmemReq.addr  = dmemAddrBits'(aluResult[dmemAddrW+1:2]);
  assign dmemReq.wdata = rtValue;

  // memory is word-only, low address bits must be clear on lw/sw
  aMemAligned : assert property (@(posedge clk) disable iff (!rst)
    (ctrl.memToReg || ctrl.memWrite) |-> (aluResult[1:0] == 2'b00))
    else $error("unaligned data access at %h", aluResult);

endmodule
